// File: project.f
rtl/host_io_pkg.sv
rtl/memory_map_pkg.sv
rtl/download_select.sv
rtl/halfword_packer.sv
rtl/cart_write_port.sv
rtl/backup_control.sv
rtl/rom_loader_top.sv
testbench/rom_loader_tb.sv

// File: Makefile
# Verilator build and run for the rom_loader testbench

VERILATOR ?= verilator
TOP       ?= rom_loader_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/rom_loader_tb.sv
// Memory model answers each ram_wr within 1 to 4 cycles and keeps one write in flight
`timescale 1ns/100ps

module rom_loader_tb;

	localparam int CLK_PERIOD     = 20;
	localparam int NUM_ENTRIES    = 10;
	localparam int TIMEOUT_CYCLES = 4 * NUM_ENTRIES * 12 + 200;

	// One download with host index, address, both halfwords, expected word and target address
	typedef struct packed {
		logic [7:0]  file_index;
		logic [26:0] addr;
		logic [15:0] first;
		logic [15:0] second;
		logic [31:0] word;
		logic [26:0] target;
	} stim_t;

	logic clk_1x, reset;
	logic ioctl_download, ioctl_wr, ram_ready;
	logic [7:0] ioctl_index;
	logic [26:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic ioctl_wait, ram_wr, cart_loaded, pif_wren;
	logic [26:0] ram_addr;
	logic [31:0] ram_data, pif_wrdata, img_size;
	logic [9:0] pif_wraddress;
	logic load_request, save_request, autosave_off, osd_open;
	logic img_mounted, img_readonly, change_pending;
	logic bk_load, bk_save, use_img, led_user;

	stim_t       stim_table [NUM_ENTRIES];
	int          cycle_count;
	int          ram_wr_count;
	int          cart_entries;
	logic        cart_seen;
	logic [31:0] lfsr_state;

	rom_loader_top rom_loader_top_inst (
		.clk_1x(clk_1x), .reset(reset), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_wait(ioctl_wait), .ram_ready(ram_ready),
		.ram_wr(ram_wr), .ram_addr(ram_addr), .ram_data(ram_data),
		.cart_loaded(cart_loaded), .pif_wren(pif_wren), .pif_wraddress(pif_wraddress),
		.pif_wrdata(pif_wrdata), .load_request(load_request), .save_request(save_request),
		.autosave_off(autosave_off), .osd_open(osd_open), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .img_size(img_size), .change_pending(change_pending),
		.bk_load(bk_load), .bk_save(bk_save), .use_img(use_img), .led_user(led_user)
	);

	initial begin
		clk_1x = 1'b0;
		forever #(CLK_PERIOD / 2) clk_1x = ~clk_1x;
	end

	always @(posedge clk_1x) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error: time %0t signal %s got %h expected %h", $time, name, actual,
				expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// ======================================================================
	// Memory model answering each write with a one-cycle ready
	// ======================================================================

	initial begin
		logic [1:0] pick;
		int         ready_delay;
		ram_ready    = 1'b0;
		ram_wr_count = 0;
		lfsr_state   = 32'ha669_d859;
		forever begin
			@(negedge clk_1x);
			if (ram_wr) begin
				ram_wr_count = ram_wr_count + 1;
				lfsr_state   = lfsr_step(lfsr_state);
				pick[0]      = lfsr_state[0];
				lfsr_state   = lfsr_step(lfsr_state);
				pick[1]      = lfsr_state[0];
				ready_delay  = int'(pick) + 1;
				repeat (ready_delay - 1) @(negedge clk_1x);
				ram_ready = 1'b1;
				@(negedge clk_1x);
				ram_ready = 1'b0;
			end
		end
	end

	// ======================================================================
	// Host model
	// ======================================================================

	// Sends one word as two halfwords and follows it through the pipeline
	task automatic send_entry(input stim_t e);
		logic is_cart;
		logic ready_seen;
		is_cart = (e.file_index[5:0] == 6'd1);
		@(negedge clk_1x);
		ioctl_download = 1'b1;
		ioctl_index    = e.file_index;
		ioctl_wr       = 1'b1;
		ioctl_addr     = e.addr;
		ioctl_dout     = e.first;
		@(negedge clk_1x);
		ioctl_addr = e.addr | 27'h2;
		ioctl_dout = e.second;
		@(negedge clk_1x);
		ioctl_wr = 1'b0;
		check_value("pif_wren", 32'(pif_wren), 32'd0);
		@(negedge clk_1x);
		// PIF word is out 2 cycles after the second strobe
		check_value("pif_wren", 32'(pif_wren), 32'(!is_cart));
		if (!is_cart) begin
			check_value("pif_wrdata", pif_wrdata, e.word);
			check_value("pif_wraddress", 32'(pif_wraddress), 32'(e.target));
		end
		@(negedge clk_1x);
		if (is_cart)
			cart_seen = 1'b1;
		check_value("pif_wren", 32'(pif_wren), 32'd0);
		check_value("ram_wr", 32'(ram_wr), 32'(is_cart));
		check_value("cart_loaded", 32'(cart_loaded), 32'(cart_seen));
		check_value("ioctl_wait", 32'(ioctl_wait), 32'(is_cart));
		if (is_cart) begin
			check_value("ram_data", ram_data, e.word);
			check_value("ram_addr", 32'(ram_addr), 32'(e.target));
			ready_seen = 1'b0;
			while (!ready_seen) begin
				@(posedge clk_1x);
				ready_seen = ram_ready;
				@(negedge clk_1x);
				check_value("ioctl_wait", 32'(ioctl_wait), 32'(!ready_seen));
				check_value("ram_wr", 32'(ram_wr), 32'd0);
			end
		end
		// Idle gap before the next strobe
		@(negedge clk_1x);
	endtask

	task automatic fill_table();
		// PIF words hold first low, first high, second low, second high from bit 31 down
		stim_table[0] = {8'h00, 27'h0000000, 16'h1234, 16'h5678, 32'h3412_7856, 27'h000};
		stim_table[1] = {8'h00, 27'h00007fc, 16'ha1b2, 16'hc3d4, 32'hb2a1_d4c3, 27'h1ff};
		stim_table[2] = {8'h40, 27'h0000010, 16'hdead, 16'hbeef, 32'hadde_efbe, 27'h204};
		stim_table[3] = {8'h40, 27'h0000404, 16'h0f1e, 16'h2d3c, 32'h1e0f_3c2d, 27'h301};
		stim_table[4] = {8'h80, 27'h0000020, 16'h5a5a, 16'ha5a5, 32'h5a5a_a5a5, 27'h008};
		// Cartridge words carry the second halfword on top and the address plus 8 MiB
		stim_table[5] = {8'h01, 27'h0000000, 16'h8037, 16'h1240, 32'h1240_8037, 27'h0800000};
		stim_table[6] = {8'h01, 27'h0000004, 16'h0000, 16'h000f, 32'h000f_0000, 27'h0800004};
		stim_table[7] = {8'h01, 27'h0123458, 16'hcafe, 16'hf00d, 32'hf00d_cafe, 27'h0923458};
		stim_table[8] = {8'h41, 27'h07ffffc, 16'h1111, 16'h2222, 32'h2222_1111, 27'h0fffffc};
		stim_table[9] = {8'h01, 27'h7800000, 16'h4321, 16'h8765, 32'h8765_4321, 27'h0000000};
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		cycle_count = 0;
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_wr = 1'b0;
		ioctl_addr = 27'd0;
		ioctl_dout = 16'd0;
		load_request = 1'b0;
		save_request = 1'b0;
		autosave_off = 1'b0;
		osd_open = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = 32'd0;
		change_pending = 1'b0;
		cart_seen = 1'b0;
		cart_entries = 0;
		fill_table();
		repeat (10) @(posedge clk_1x);
		@(negedge clk_1x);
		reset = 1'b0;
		@(negedge clk_1x);
		check_value("pif_wren", 32'(pif_wren), 32'd0);
		check_value("ram_wr", 32'(ram_wr), 32'd0);
		check_value("ioctl_wait", 32'(ioctl_wait), 32'd0);
		check_value("cart_loaded", 32'(cart_loaded), 32'd0);
		check_value("use_img", 32'(use_img), 32'd0);
		check_value("bk_save", 32'(bk_save), 32'd0);

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (stim_table[i].file_index[5:0] == 6'd1)
				cart_entries = cart_entries + 1;
			send_entry(stim_table[i]);
		end
		check_value("ram_wr count", 32'(ram_wr_count), 32'(cart_entries));

		// Backup requests with the download closed
		ioctl_download = 1'b0;
		load_request = 1'b1;
		@(negedge clk_1x);
		check_value("led_user", 32'(led_user), 32'd0);
		check_value("bk_load", 32'(bk_load), 32'd1);
		check_value("bk_save", 32'(bk_save), 32'd0);
		load_request = 1'b0;
		save_request = 1'b1;
		@(negedge clk_1x);
		check_value("bk_load", 32'(bk_load), 32'd0);
		check_value("bk_save", 32'(bk_save), 32'd1);
		save_request = 1'b0;
		osd_open = 1'b1;
		// Edge is only visible until the next rising clock
		#(CLK_PERIOD / 4);
		check_value("bk_save", 32'(bk_save), 32'd1);
		@(negedge clk_1x);
		check_value("bk_save", 32'(bk_save), 32'd0);
		osd_open = 1'b0;
		autosave_off = 1'b1;
		@(negedge clk_1x);
		osd_open = 1'b1;
		#(CLK_PERIOD / 4);
		check_value("bk_save", 32'(bk_save), 32'd0);

		// Mount rules
		@(negedge clk_1x);
		img_mounted = 1'b1;
		@(negedge clk_1x);
		check_value("use_img", 32'(use_img), 32'd0);
		img_size = 32'd8192;
		img_readonly = 1'b1;
		@(negedge clk_1x);
		check_value("use_img", 32'(use_img), 32'd0);
		img_readonly = 1'b0;
		@(negedge clk_1x);
		check_value("use_img", 32'(use_img), 32'd1);

		// New cartridge download drops the image
		ioctl_download = 1'b1;
		ioctl_index = 8'h01;
		img_readonly = 1'b1;
		@(negedge clk_1x);
		check_value("led_user", 32'(led_user), 32'd1);
		check_value("bk_load", 32'(bk_load), 32'd1);
		check_value("use_img", 32'(use_img), 32'd1);
		@(negedge clk_1x);
		check_value("use_img", 32'(use_img), 32'd0);
		ioctl_download = 1'b0;
		img_mounted = 1'b0;
		@(negedge clk_1x);
		check_value("led_user", 32'(led_user), 32'd0);
		check_value("bk_load", 32'(bk_load), 32'd0);
		change_pending = 1'b1;
		@(negedge clk_1x);
		check_value("led_user", 32'(led_user), 32'd1);
		check_value("cart_loaded", 32'(cart_loaded), 32'd1);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: rtl/rom_loader_top.sv
// ROM download pipeline top; the host keeps 4 idle cycles after each second-half strobe
`timescale 1ns/100ps

module rom_loader_top (
	input  logic                      clk_1x,
	input  logic                      reset,
	input  logic                      ioctl_download,
	input  host_io_pkg::file_index_t  ioctl_index,
	input  logic                      ioctl_wr,
	input  host_io_pkg::host_addr_t   ioctl_addr,
	input  host_io_pkg::halfword_t    ioctl_dout,
	output logic                      ioctl_wait,
	input  logic                      ram_ready,
	output logic                      ram_wr,
	output memory_map_pkg::ram_addr_t ram_addr,
	output memory_map_pkg::word_t     ram_data,
	output logic                      cart_loaded,
	output logic                      pif_wren,
	output memory_map_pkg::pif_addr_t pif_wraddress,
	output memory_map_pkg::word_t     pif_wrdata,
	input  logic                      load_request,
	input  logic                      save_request,
	input  logic                      autosave_off,
	input  logic                      osd_open,
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic [31:0]               img_size,
	input  logic                      change_pending,
	output logic                      bk_load,
	output logic                      bk_save,
	output logic                      use_img,
	output logic                      led_user
);

	import host_io_pkg::*;
	import memory_map_pkg::*;

	logic      pif_half_wr;
	logic      cart_half_wr;
	logic      upper_half;
	logic      cart_active;
	halfword_t half_data;
	pif_addr_t pif_addr;
	ram_addr_t cart_addr;
	logic      cart_word_wr;
	word_t     cart_word_data;
	ram_addr_t cart_word_addr;

	download_select download_select_inst (
		.clk_1x(clk_1x), .reset(reset), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .pif_half_wr(pif_half_wr), .cart_half_wr(cart_half_wr),
		.upper_half(upper_half), .cart_active(cart_active), .half_data(half_data),
		.pif_addr(pif_addr), .cart_addr(cart_addr)
	);

	// Boot ROM words go straight out
	halfword_packer #(.addr_t(pif_addr_t), .swap_bytes(1'b1)) pif_packer (
		.clk_1x(clk_1x), .reset(reset), .half_wr(pif_half_wr), .upper_half(upper_half),
		.half_data(half_data), .half_addr(pif_addr), .word_wr(pif_wren),
		.word_data(pif_wrdata), .word_addr(pif_wraddress)
	);

	halfword_packer #(.addr_t(ram_addr_t), .swap_bytes(1'b0)) cart_packer (
		.clk_1x(clk_1x), .reset(reset), .half_wr(cart_half_wr), .upper_half(upper_half),
		.half_data(half_data), .half_addr(cart_addr), .word_wr(cart_word_wr),
		.word_data(cart_word_data), .word_addr(cart_word_addr)
	);

	cart_write_port cart_write_port_inst (
		.clk_1x(clk_1x), .reset(reset), .word_wr(cart_word_wr), .cart_active(cart_active),
		.ram_ready(ram_ready), .word_data(cart_word_data), .word_addr(cart_word_addr),
		.ram_wr(ram_wr), .ioctl_wait(ioctl_wait), .cart_loaded(cart_loaded),
		.ram_data(ram_data), .ram_addr(ram_addr)
	);

	backup_control backup_control_inst (
		.clk_1x(clk_1x), .reset(reset), .cart_active(cart_active),
		.load_request(load_request), .save_request(save_request),
		.autosave_off(autosave_off), .osd_open(osd_open), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .img_size(img_size), .change_pending(change_pending),
		.bk_load(bk_load), .bk_save(bk_save), .use_img(use_img), .led_user(led_user)
	);

endmodule

// File: rtl/backup_control.sv
// Backup request logic; bk_load and led_user are combinational, img_size is nonzero for usable images
`timescale 1ns/100ps

module backup_control (
	input  logic        clk_1x,
	input  logic        reset,
	input  logic        cart_active,
	input  logic        load_request,
	input  logic        save_request,
	input  logic        autosave_off,
	input  logic        osd_open,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [31:0] img_size,
	input  logic        change_pending,
	output logic        bk_load,
	output logic        bk_save,
	output logic        use_img,
	output logic        led_user
);

	logic osd_open_d;
	logic cart_active_d;
	logic osd_rise;

	assign osd_rise = osd_open & ~osd_open_d;

	// ======================================================================
	// Load and save requests
	// ======================================================================

	// A mounted image reloads while a cartridge comes in
	assign bk_load = load_request | (cart_active & img_mounted);

	// Autosave on menu open
	assign bk_save = save_request | (osd_rise & ~autosave_off);

	assign led_user = cart_active | change_pending;

	// ======================================================================
	// Mounted image state
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			osd_open_d    <= 1'b0;
			cart_active_d <= 1'b0;
			use_img       <= 1'b0;
		end else begin
			osd_open_d    <= osd_open;
			cart_active_d <= cart_active;
			// New cartridge drops the old image
			if (cart_active & ~cart_active_d)
				use_img <= 1'b0;
			if (img_mounted && (img_size != 32'd0) && !img_readonly)
				use_img <= 1'b1;
		end
	end

endmodule

// File: rtl/cart_write_port.sv
// Memory write stage; ram_ready is taken as the answer to the last ram_wr, one write in flight
`timescale 1ns/100ps

module cart_write_port (
	input  logic                      clk_1x,
	input  logic                      reset,
	input  logic                      word_wr,
	input  logic                      cart_active,
	input  logic                      ram_ready,
	input  memory_map_pkg::word_t     word_data,
	input  memory_map_pkg::ram_addr_t word_addr,
	output logic                      ram_wr,
	output logic                      ioctl_wait,
	output logic                      cart_loaded,
	output memory_map_pkg::word_t     ram_data,
	output memory_map_pkg::ram_addr_t ram_addr
);

	always_ff @(posedge clk_1x) begin
		if (word_wr) begin
			ram_data <= word_data;
			ram_addr <= word_addr;
		end
	end

	// ======================================================================
	// Write request and host hold
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			ram_wr      <= 1'b0;
			ioctl_wait  <= 1'b0;
			cart_loaded <= 1'b0;
		end else begin
			ram_wr <= word_wr;
			// Stays set until reset
			if (cart_active)
				cart_loaded <= 1'b1;
			if (!cart_active)
				ioctl_wait <= 1'b0;
			else if (word_wr)
				ioctl_wait <= 1'b1;
			else if (ram_ready)
				ioctl_wait <= 1'b0;
		end
	end

endmodule

// File: rtl/halfword_packer.sv
// Joins two halfwords into a word; the first half must arrive before the second, address from first
`timescale 1ns/100ps

module halfword_packer #(
	parameter type addr_t     = logic [9:0],
	parameter bit  swap_bytes = 1'b0
) (
	input  logic                   clk_1x,
	input  logic                   reset,
	input  logic                   half_wr,
	input  logic                   upper_half,
	input  host_io_pkg::halfword_t half_data,
	input  addr_t                  half_addr,
	output logic                   word_wr,
	output memory_map_pkg::word_t  word_data,
	output addr_t                  word_addr
);

	import host_io_pkg::*;

	halfword_t half_ordered;
	logic      goes_high;

	// PIF data is byte swapped within each halfword
	assign half_ordered = swap_bytes ? {half_data[7:0], half_data[15:8]} : half_data;

	// Swapped order puts the first half on top, straight order at the bottom
	assign goes_high = upper_half ^ swap_bytes;

	// ======================================================================
	// Word assembly
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (half_wr) begin
			if (goes_high)
				word_data[31:16] <= half_ordered;
			else
				word_data[15:0] <= half_ordered;
			if (!upper_half)
				word_addr <= half_addr;
		end
	end

	// Pulse once the second half is in
	always_ff @(posedge clk_1x) begin
		if (reset)
			word_wr <= 1'b0;
		else
			word_wr <= half_wr & upper_half;
	end

endmodule

// File: rtl/download_select.sv
// First stage; the host must not strobe while ioctl_wait is high, outputs lag the host by one cycle
`timescale 1ns/100ps

module download_select (
	input  logic                     clk_1x,
	input  logic                     reset,
	input  logic                     ioctl_download,
	input  host_io_pkg::file_index_t ioctl_index,
	input  logic                     ioctl_wr,
	input  host_io_pkg::host_addr_t  ioctl_addr,
	input  host_io_pkg::halfword_t   ioctl_dout,
	output logic                     pif_half_wr,
	output logic                     cart_half_wr,
	output logic                     upper_half,
	output logic                     cart_active,
	output host_io_pkg::halfword_t   half_data,
	output memory_map_pkg::pif_addr_t pif_addr,
	output memory_map_pkg::ram_addr_t cart_addr
);

	import host_io_pkg::*;
	import memory_map_pkg::*;

	logic is_pif;
	logic is_cart;

	// Index decode, done once for both targets
	assign is_pif  = ioctl_download && (ioctl_index[5:0] == INDEX_PIF);
	assign is_cart = ioctl_download && (ioctl_index[5:0] == INDEX_CART);

	// ======================================================================
	// Strobes and download level
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (reset) begin
			pif_half_wr  <= 1'b0;
			cart_half_wr <= 1'b0;
			cart_active  <= 1'b0;
		end else begin
			pif_half_wr  <= ioctl_wr & is_pif;
			cart_half_wr <= ioctl_wr & is_cart;
			cart_active  <= is_cart;
		end
	end

	// ======================================================================
	// Halfword and target addresses
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (ioctl_wr) begin
			// Bit 1 set marks the second half of a word
			upper_half <= ioctl_addr[1];
			half_data  <= ioctl_dout;
			// Bank bit on top of the word index
			pif_addr   <= {ioctl_index[PIF_BANK_BIT], ioctl_addr[10:2]};
			cart_addr  <= ioctl_addr + CART_BASE;
		end
	end

endmodule

// File: rtl/memory_map_pkg.sv
// Target memory types; cartridge addresses are byte addresses, PIF addresses are word addresses
package memory_map_pkg;

	// ======================================================================
	// Targets of the download
	// ======================================================================

	// One assembled 32-bit word
	typedef logic [31:0] word_t;

	// PIF boot ROM, 1024 words of 32 bits
	typedef logic [9:0] pif_addr_t;

	// Cartridge memory byte address
	typedef logic [26:0] ram_addr_t;

	// Cartridge image starts at 8 MiB
	localparam ram_addr_t CART_BASE = 27'd8388608;

endpackage

// File: rtl/host_io_pkg.sv
// Host download port types and file index codes; index codes compare on index bits 5..0 only
package host_io_pkg;

	// ======================================================================
	// Host download port
	// ======================================================================

	// Byte address of the halfword on the host bus
	typedef logic [26:0] host_addr_t;

	typedef logic [15:0] halfword_t;

	// Full download index as sent by the host
	typedef logic [7:0] file_index_t;

	// Index code, the low six bits of the download index
	typedef logic [5:0] index_code_t;

	localparam index_code_t INDEX_PIF  = 6'd0;
	localparam index_code_t INDEX_CART = 6'd1;

	// Selects the upper half of the PIF ROM
	localparam int PIF_BANK_BIT = 6;

endpackage
